/* Bender.yml */
package:
  name: lpif_txrx_slave

sources:
  - lpif_pkg.sv
  - lpif_sync_if.sv
  - lpif_auto_sync.sv
  - lpif_name.sv
  - lpif_concat.sv
  - lpif_txrx_slave_top.sv
  - target: test
    files:
      - lpif_txrx_slave_assertions.sv
      - lpif_txrx_slave_tb.sv

/* all.f */
lpif_pkg.sv
lpif_sync_if.sv
lpif_auto_sync.sv
lpif_name.sv
lpif_concat.sv
lpif_txrx_slave_top.sv
lpif_txrx_slave_assertions.sv
lpif_txrx_slave_tb.sv

/* lpif_auto_sync.sv */
`timescale 1ns/100ps

module lpif_auto_sync (
  input  logic        clk_wr,
  input  logic        rst_n,
  input  logic        tx_online,
  input  logic        rx_online,
  input  logic [15:0] delay_x_value,
  input  logic [15:0] delay_y_value,
  lpif_sync_if.src    sync
);

  // Tracker 0 is tx, tracker 1 is rx
  localparam int TX = 0;
  localparam int RX = 1;

  logic [1:0]            online_in;
  logic [1:0][15:0]      delay_val;
  lpif_pkg::sync_state_e state_q [2];
  logic [15:0]           cnt_q [2];
  logic                  tx_online_dly;
  logic                  rx_online_dly;

  assign online_in = {rx_online, tx_online};
  assign delay_val = {delay_x_value, delay_y_value};

  ////////////////////
  // Online trackers

  // cnt_q holds the number of high samples seen so far
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 2; i++) begin
        state_q[i] <= lpif_pkg::OFFLINE;
        cnt_q[i]   <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        case (state_q[i])
          lpif_pkg::OFFLINE: begin
            if (online_in[i]) begin
              cnt_q[i]   <= 16'd1;
              // Zero delay goes straight online
              state_q[i] <= (delay_val[i] == '0) ? lpif_pkg::ONLINE : lpif_pkg::COUNTING;
            end
          end
          lpif_pkg::COUNTING: begin
            if (!online_in[i]) begin
              state_q[i] <= lpif_pkg::OFFLINE;
              cnt_q[i]   <= '0;
            end else if (cnt_q[i] >= delay_val[i]) begin
              state_q[i] <= lpif_pkg::ONLINE;
            end else begin
              cnt_q[i] <= cnt_q[i] + 16'd1;
            end
          end
          lpif_pkg::ONLINE: begin
            // Drop on the first low sample
            if (!online_in[i]) begin
              state_q[i] <= lpif_pkg::OFFLINE;
              cnt_q[i]   <= '0;
            end
          end
          default: begin
            state_q[i] <= lpif_pkg::OFFLINE;
            cnt_q[i]   <= '0;
          end
        endcase
      end
    end
  end

  assign tx_online_dly = (state_q[TX] == lpif_pkg::ONLINE);
  assign rx_online_dly = (state_q[RX] == lpif_pkg::ONLINE);

  ////////////////////
  // Outputs to the lane logic
  assign sync.tx_online_delay = tx_online_dly;
  assign sync.rx_online_delay = rx_online_dly;

  // Persistent strobe and marker
  assign sync.tx_stb_userbit = tx_online_dly;
  assign sync.tx_mrk_userbit = tx_online_dly;

endmodule

/* lpif_concat.sv */
`timescale 1ns/100ps

module lpif_concat #(
  parameter int NUM_LANES = 3
) (
  input  logic                                        clk_wr,
  input  logic                                        rst_n,
  lpif_sync_if.snk                                    sync,
  input  logic [lpif_pkg::LPIF_WORD_W-1:0]            tx_word,
  output logic [lpif_pkg::LPIF_WORD_W-1:0]            rx_word,
  output logic [NUM_LANES*lpif_pkg::LPIF_LANE_W-1:0]  tx_phy,
  input  logic [NUM_LANES*lpif_pkg::LPIF_LANE_W-1:0]  rx_phy,
  output logic [31:0]                                 rx_debug_status,
  output logic [31:0]                                 tx_debug_status
);

  localparam int LANE_W    = lpif_pkg::LPIF_LANE_W;
  localparam int SLICE_W   = lpif_pkg::LPIF_SLICE_W;
  localparam int SLICE_LSB = LANE_W - SLICE_W;
  localparam int PAD_W     = NUM_LANES * SLICE_W;
  localparam int PHY_W     = NUM_LANES * LANE_W;

  logic [lpif_pkg::LPIF_WORD_W-1:0] tx_word_q;
  logic [lpif_pkg::LPIF_WORD_W-1:0] rx_word_q;
  logic [PAD_W-1:0]                 tx_pad;
  logic [PAD_W-1:0]                 rx_pad;
  logic [PHY_W-1:0]                 tx_lanes;
  logic [NUM_LANES-1:0]             rx_stb;
  logic [15:0]                      tx_word_cnt;
  logic [15:0]                      rx_word_cnt;
  logic [15:0]                      stb_err_cnt;

  function automatic logic [15:0] sat_inc(input logic [15:0] cnt);
    return (cnt == lpif_pkg::LPIF_CNT_MAX) ? cnt : cnt + 16'd1;
  endfunction

  ////////////////////
  // tx lane striping
  always_ff @(posedge clk_wr) begin
    tx_word_q <= tx_word;
  end

  // Spare bits of the last lane go out as zero
  assign tx_pad = PAD_W'(tx_word_q);

  always_comb begin
    tx_lanes = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      tx_lanes[k*LANE_W + SLICE_LSB +: SLICE_W]     = tx_pad[k*SLICE_W +: SLICE_W];
      tx_lanes[k*LANE_W + lpif_pkg::LPIF_STB_BIT] = sync.tx_stb_userbit;
      tx_lanes[k*LANE_W + lpif_pkg::LPIF_MRK_BIT] = sync.tx_mrk_userbit;
    end
  end

  // Quiet lanes until tx is up
  assign tx_phy = sync.tx_online_delay ? tx_lanes : '0;

  ////////////////////
  // rx lane collection
  always_comb begin
    rx_pad = '0;
    rx_stb = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      rx_pad[k*SLICE_W +: SLICE_W] = rx_phy[k*LANE_W + SLICE_LSB +: SLICE_W];
      rx_stb[k]                    = rx_phy[k*LANE_W + lpif_pkg::LPIF_STB_BIT];
    end
  end

  always_ff @(posedge clk_wr) begin
    rx_word_q <= rx_pad[lpif_pkg::LPIF_WORD_W-1:0];
  end

  assign rx_word = sync.rx_online_delay ? rx_word_q : '0;

  ////////////////////
  // Debug counters
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_word_cnt <= '0;
      rx_word_cnt <= '0;
      stb_err_cnt <= '0;
    end else begin
      if (sync.tx_online_delay && tx_word[lpif_pkg::LPIF_VALID_POS]) begin
        tx_word_cnt <= sat_inc(tx_word_cnt);
      end
      if (sync.rx_online_delay && rx_pad[lpif_pkg::LPIF_VALID_POS]) begin
        rx_word_cnt <= sat_inc(rx_word_cnt);
      end
      // One count per cycle, however many lanes miss the strobe
      if (sync.rx_online_delay && !(&rx_stb)) begin
        stb_err_cnt <= sat_inc(stb_err_cnt);
      end
    end
  end

  assign tx_debug_status = {16'h0, tx_word_cnt};
  assign rx_debug_status = {stb_err_cnt, rx_word_cnt};

endmodule

/* lpif_name.sv */
`timescale 1ns/100ps

module lpif_name (
  // Upstream flit
  input  logic [lpif_pkg::LPIF_STATE_W-1:0]  ustrm_state,
  input  logic [lpif_pkg::LPIF_PROTID_W-1:0] ustrm_protid,
  input  logic [lpif_pkg::LPIF_DATA_W-1:0]   ustrm_data,
  input  logic                               ustrm_dvalid,
  input  logic [lpif_pkg::LPIF_CRC_W-1:0]    ustrm_crc,
  input  logic                               ustrm_crc_valid,
  input  logic                               ustrm_valid,

  output logic [lpif_pkg::LPIF_WORD_W-1:0]   tx_word,
  input  logic [lpif_pkg::LPIF_WORD_W-1:0]   rx_word,

  // Downstream flit
  output logic [lpif_pkg::LPIF_STATE_W-1:0]  dstrm_state,
  output logic [lpif_pkg::LPIF_PROTID_W-1:0] dstrm_protid,
  output logic [lpif_pkg::LPIF_DATA_W-1:0]   dstrm_data,
  output logic                               dstrm_dvalid,
  output logic [lpif_pkg::LPIF_CRC_W-1:0]    dstrm_crc,
  output logic                               dstrm_crc_valid,
  output logic                               dstrm_valid
);

  ////////////////////
  // Pack upstream fields
  always_comb begin
    tx_word = '0;
    tx_word[lpif_pkg::LPIF_VALID_POS]                           = ustrm_valid;
    tx_word[lpif_pkg::LPIF_CRCV_POS]                            = ustrm_crc_valid;
    tx_word[lpif_pkg::LPIF_CRC_POS +: lpif_pkg::LPIF_CRC_W]       = ustrm_crc;
    tx_word[lpif_pkg::LPIF_DVALID_POS]                          = ustrm_dvalid;
    tx_word[lpif_pkg::LPIF_DATA_POS +: lpif_pkg::LPIF_DATA_W]     = ustrm_data;
    tx_word[lpif_pkg::LPIF_PROTID_POS +: lpif_pkg::LPIF_PROTID_W] = ustrm_protid;
    tx_word[lpif_pkg::LPIF_STATE_POS +: lpif_pkg::LPIF_STATE_W]   = ustrm_state;
  end

  ////////////////////
  // Unpack downstream fields

  // rx_word is already zero while rx is offline
  assign dstrm_valid     = rx_word[lpif_pkg::LPIF_VALID_POS];
  assign dstrm_crc_valid = rx_word[lpif_pkg::LPIF_CRCV_POS];
  assign dstrm_crc       = rx_word[lpif_pkg::LPIF_CRC_POS +: lpif_pkg::LPIF_CRC_W];
  assign dstrm_dvalid    = rx_word[lpif_pkg::LPIF_DVALID_POS];
  assign dstrm_data      = rx_word[lpif_pkg::LPIF_DATA_POS +: lpif_pkg::LPIF_DATA_W];
  assign dstrm_protid    = rx_word[lpif_pkg::LPIF_PROTID_POS +: lpif_pkg::LPIF_PROTID_W];
  assign dstrm_state     = rx_word[lpif_pkg::LPIF_STATE_POS +: lpif_pkg::LPIF_STATE_W];

endmodule

/* lpif_pkg.sv */
package lpif_pkg;

  // Flit field widths
  localparam int LPIF_STATE_W  = 4;
  localparam int LPIF_PROTID_W = 2;
  localparam int LPIF_DATA_W   = 64;
  localparam int LPIF_CRC_W    = 16;

  ////////////////////
  // Word layout, packed from bit 0 upwards
  localparam int LPIF_VALID_POS  = 0;
  localparam int LPIF_CRCV_POS   = LPIF_VALID_POS + 1;
  localparam int LPIF_CRC_POS    = LPIF_CRCV_POS + 1;
  localparam int LPIF_DVALID_POS = LPIF_CRC_POS + LPIF_CRC_W;
  localparam int LPIF_DATA_POS   = LPIF_DVALID_POS + 1;
  localparam int LPIF_PROTID_POS = LPIF_DATA_POS + LPIF_DATA_W;
  localparam int LPIF_STATE_POS  = LPIF_PROTID_POS + LPIF_PROTID_W;

  // 89 bits in total
  localparam int LPIF_WORD_W = LPIF_STATE_POS + LPIF_STATE_W;

  ////////////////////
  // PHY lane layout
  localparam int LPIF_LANE_W  = 40;
  localparam int LPIF_STB_BIT = 0;
  localparam int LPIF_MRK_BIT = 1;
  // Payload sits in lane bits 39:2
  localparam int LPIF_SLICE_W = 38;

  // Bring-up tracker states, shared by tx and rx
  typedef enum logic [1:0] {
    OFFLINE,
    COUNTING,
    ONLINE
  } sync_state_e;

  // Debug counters stick here
  localparam logic [15:0] LPIF_CNT_MAX = 16'hffff;

endpackage

/* lpif_sync_if.sv */
`timescale 1ns/100ps

interface lpif_sync_if;

  // Online flags after the bring-up delay
  logic tx_online_delay;
  logic rx_online_delay;

  // Lane user bits, held for as long as tx is online
  logic tx_stb_userbit;
  logic tx_mrk_userbit;

  modport src (
    output tx_online_delay,
    output rx_online_delay,
    output tx_stb_userbit,
    output tx_mrk_userbit
  );

  modport snk (
    input tx_online_delay,
    input rx_online_delay,
    input tx_stb_userbit,
    input tx_mrk_userbit
  );

endinterface

/* lpif_txrx_slave_assertions.sv */
`timescale 1ns/100ps

module lpif_txrx_slave_assertions #(
  parameter int NUM_LANES = 3
) (
  input logic                                       clk_wr,
  input logic                                       rst_n,
  input logic                                       tx_online_delay,
  input logic                                       rx_online_delay,
  input logic [NUM_LANES*lpif_pkg::LPIF_LANE_W-1:0] tx_phy,
  input logic [lpif_pkg::LPIF_WORD_W-1:0]           dstrm_flat,
  input logic [31:0]                                rx_status,
  input logic [31:0]                                tx_status
);

  int   fail_cnt = 0;
  logic lane_flags_ok;

  // Strobe and marker of every lane
  always_comb begin
    lane_flags_ok = 1'b1;
    for (int k = 0; k < NUM_LANES; k++) begin
      lane_flags_ok &= tx_phy[k*lpif_pkg::LPIF_LANE_W + lpif_pkg::LPIF_STB_BIT];
      lane_flags_ok &= tx_phy[k*lpif_pkg::LPIF_LANE_W + lpif_pkg::LPIF_MRK_BIT];
    end
  end

  tx_quiet: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !tx_online_delay |-> tx_phy == '0)
    else begin
      fail_cnt++;
      $error("tx_phy not zero while tx is offline");
    end

  lanes_flagged: assert property (@(posedge clk_wr) disable iff (!rst_n)
    tx_online_delay |-> lane_flags_ok)
    else begin
      fail_cnt++;
      $error("lane strobe or marker missing while tx is online");
    end

  rx_quiet: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !rx_online_delay |-> dstrm_flat == '0)
    else begin
      fail_cnt++;
      $error("dstrm outputs not zero while rx is offline");
    end

  ////////////////////
  // Counters only move up
  cnt_monotonic: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (rx_status[15:0] >= $past(rx_status[15:0])) &&
    (rx_status[31:16] >= $past(rx_status[31:16])) &&
    (tx_status[15:0] >= $past(tx_status[15:0])))
    else begin
      fail_cnt++;
      $error("debug counter decreased");
    end

endmodule

bind lpif_txrx_slave_top lpif_txrx_slave_assertions #(.NUM_LANES(NUM_LANES)) assertions_inst (
  .clk_wr          (clk_wr),
  .rst_n           (rst_n),
  .tx_online_delay (sync_if.tx_online_delay),
  .rx_online_delay (sync_if.rx_online_delay),
  .tx_phy          (tx_phy),
  .dstrm_flat      ({dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                     dstrm_crc, dstrm_crc_valid, dstrm_valid}),
  .rx_status       (rx_downstream_debug_status),
  .tx_status       (tx_upstream_debug_status)
);

/* lpif_txrx_slave_tb.sv */
`timescale 1ns/100ps

module lpif_txrx_slave_tb;

  localparam int NUM_LANES   = 3;
  localparam int LANE_W      = lpif_pkg::LPIF_LANE_W;
  localparam int PHY_W       = NUM_LANES * LANE_W;
  // Cycles for reset, quiet, tx bring-up, loopback, rx gating and strobe errors
  localparam int TEST_CYCLES = 3 + 1 + 7 + 31 + 11 + 15;
  localparam int TIMEOUT_NS  = TEST_CYCLES * 20 * 2;

  typedef struct packed {
    logic [lpif_pkg::LPIF_STATE_W-1:0]  state;
    logic [lpif_pkg::LPIF_PROTID_W-1:0] protid;
    logic [lpif_pkg::LPIF_DATA_W-1:0]   data;
    logic                               dvalid;
    logic [lpif_pkg::LPIF_CRC_W-1:0]    crc;
    logic                               crc_valid;
    logic                               valid;
  } flit_t;

  logic clk_wr = 1'b0;
  logic rst_n;
  logic tx_online;
  logic rx_online;
  logic [15:0] delay_x_value;
  logic [15:0] delay_y_value;
  logic [PHY_W-1:0] tx_phy;
  logic [PHY_W-1:0] rx_phy;
  logic [PHY_W-1:0] inj_mask;
  logic [lpif_pkg::LPIF_STATE_W-1:0]  ustrm_state, dstrm_state;
  logic [lpif_pkg::LPIF_PROTID_W-1:0] ustrm_protid, dstrm_protid;
  logic [lpif_pkg::LPIF_DATA_W-1:0]   ustrm_data, dstrm_data;
  logic [lpif_pkg::LPIF_CRC_W-1:0]    ustrm_crc, dstrm_crc;
  logic ustrm_dvalid, ustrm_crc_valid, ustrm_valid;
  logic dstrm_dvalid, dstrm_crc_valid, dstrm_valid;
  logic [31:0] rx_downstream_debug_status;
  logic [31:0] tx_upstream_debug_status;
  int errors;
  // Expected debug counter values
  int exp_tx_cnt;
  int exp_rx_cnt;
  int exp_stb_err;
  // Strobe injection, one entry per driven cycle
  logic [PHY_W-1:0] mask_q[$];

  lpif_txrx_slave_top #(.NUM_LANES(NUM_LANES)) lpif_txrx_slave_top_inst (.*);

  // PHY loopback with error injection
  assign rx_phy = tx_phy ^ inj_mask;

  initial begin
    forever #10 clk_wr = ~clk_wr;
  end

  ////////////////////
  // Helpers

  task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  function automatic flit_t random_flit();
    flit_t f;
    f.state     = 4'($urandom());
    f.protid    = 2'($urandom());
    f.data      = {$urandom(), $urandom()};
    f.dvalid    = 1'($urandom());
    f.crc       = 16'($urandom());
    f.crc_valid = 1'($urandom());
    f.valid     = 1'($urandom());
    return f;
  endfunction

  task automatic drive_flit(input flit_t f);
    ustrm_state     = f.state;
    ustrm_protid    = f.protid;
    ustrm_data      = f.data;
    ustrm_dvalid    = f.dvalid;
    ustrm_crc       = f.crc;
    ustrm_crc_valid = f.crc_valid;
    ustrm_valid     = f.valid;
  endtask

  task automatic check_flit(input flit_t f);
    check_val("dstrm_state", dstrm_state, f.state);
    check_val("dstrm_protid", dstrm_protid, f.protid);
    check_val("dstrm_data", dstrm_data, f.data);
    check_val("dstrm_dvalid", dstrm_dvalid, f.dvalid);
    check_val("dstrm_crc", dstrm_crc, f.crc);
    check_val("dstrm_crc_valid", dstrm_crc_valid, f.crc_valid);
    check_val("dstrm_valid", dstrm_valid, f.valid);
  endtask

  // Both status words against the counts tracked here
  task automatic check_status();
    check_val("rx_downstream_debug_status", rx_downstream_debug_status,
              {16'(exp_stb_err), 16'(exp_rx_cnt)});
    check_val("tx_upstream_debug_status", tx_upstream_debug_status,
              {16'h0, 16'(exp_tx_cnt)});
  endtask

  task automatic check_lanes_up();
    for (int k = 0; k < NUM_LANES; k++) begin
      check_val($sformatf("tx_phy lane %0d strobe", k),
                tx_phy[k*LANE_W + lpif_pkg::LPIF_STB_BIT], 1'b1);
      check_val($sformatf("tx_phy lane %0d marker", k),
                tx_phy[k*LANE_W + lpif_pkg::LPIF_MRK_BIT], 1'b1);
    end
  endtask

  // Each flit shows on dstrm two cycles after it is driven, then two idle cycles
  task automatic stream_flits(input int n, input bit rx_up, output int n_valid);
    flit_t exp_q[$];
    flit_t f;
    flit_t exp_f;
    n_valid = 0;
    for (int i = 0; i < n + 2; i++) begin
      @(negedge clk_wr);
      if (i >= 2) begin
        exp_f = exp_q.pop_front();
        if (rx_up) check_flit(exp_f);
        else check_flit('0);
      end
      f = (i < n) ? random_flit() : '0;
      n_valid += f.valid;
      drive_flit(f);
      exp_q.push_back(f);
      inj_mask = (mask_q.size() > 0) ? mask_q.pop_front() : '0;
    end
  endtask

  ////////////////////
  // Tests

  task automatic reset_quiet();
    @(negedge clk_wr);
    check_val("tx_phy", tx_phy, '0);
    check_flit('0);
    check_status();
  endtask

  task automatic tx_bringup();
    delay_y_value = 16'd5;
    tx_online     = 1'b1;
    repeat (5) begin
      @(negedge clk_wr);
      check_val("tx_phy", tx_phy, '0);
    end
    @(negedge clk_wr);
    check_lanes_up();
    tx_online = 1'b0;
    @(negedge clk_wr);
    check_val("tx_phy", tx_phy, '0);
  endtask

  task automatic loopback_data();
    int n_valid;
    delay_x_value = 16'd2;
    tx_online     = 1'b1;
    repeat (6) @(negedge clk_wr);
    check_lanes_up();
    rx_online = 1'b1;
    repeat (3) @(negedge clk_wr);
    stream_flits(20, 1'b1, n_valid);
    // Valid flits count on both sides
    exp_tx_cnt += n_valid;
    exp_rx_cnt += n_valid;
    check_status();
  endtask

  task automatic rx_gating();
    int n_valid;
    rx_online = 1'b0;
    @(negedge clk_wr);
    stream_flits(8, 1'b0, n_valid);
    // tx keeps counting, rx word count holds
    exp_tx_cnt += n_valid;
    check_status();
  endtask

  task automatic strobe_errors();
    logic [PHY_W-1:0] m;
    int n_valid;
    rx_online = 1'b1;
    repeat (3) @(negedge clk_wr);
    m = '0;
    m[1*LANE_W + lpif_pkg::LPIF_STB_BIT] = 1'b1;
    repeat (4) mask_q.push_back(m);
    // Two lanes at once still count once per cycle
    m = '0;
    m[0*LANE_W + lpif_pkg::LPIF_STB_BIT] = 1'b1;
    m[2*LANE_W + lpif_pkg::LPIF_STB_BIT] = 1'b1;
    repeat (3) mask_q.push_back(m);
    stream_flits(10, 1'b1, n_valid);
    exp_tx_cnt  += n_valid;
    exp_rx_cnt  += n_valid;
    exp_stb_err += 7;
    check_status();
  endtask

  ////////////////////
  // Main sequence
  initial begin
    void'($urandom(32'h11f39bf2));
    errors        = 0;
    exp_tx_cnt    = 0;
    exp_rx_cnt    = 0;
    exp_stb_err   = 0;
    rst_n         = 1'b0;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    delay_x_value = '0;
    delay_y_value = '0;
    inj_mask      = '0;
    drive_flit('0);
    repeat (3) @(negedge clk_wr);
    rst_n = 1'b1;
    reset_quiet();
    tx_bringup();
    loopback_data();
    rx_gating();
    strobe_errors();
    errors += lpif_txrx_slave_top_inst.assertions_inst.fail_cnt;
    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns, the tests did not complete", TIMEOUT_NS);
    $display("** FAIL **");
    $finish;
  end

endmodule

/* lpif_txrx_slave_top.sv */
`timescale 1ns/100ps

module lpif_txrx_slave_top #(
  parameter int NUM_LANES = 3
) (
  input  logic                                        clk_wr,
  input  logic                                        rst_n,

  // Bring-up control
  input  logic                                        tx_online,
  input  logic                                        rx_online,
  input  logic [15:0]                                 delay_x_value,
  input  logic [15:0]                                 delay_y_value,

  // PHY lanes
  output logic [NUM_LANES*lpif_pkg::LPIF_LANE_W-1:0]  tx_phy,
  input  logic [NUM_LANES*lpif_pkg::LPIF_LANE_W-1:0]  rx_phy,

  // Downstream flit
  output logic [lpif_pkg::LPIF_STATE_W-1:0]           dstrm_state,
  output logic [lpif_pkg::LPIF_PROTID_W-1:0]          dstrm_protid,
  output logic [lpif_pkg::LPIF_DATA_W-1:0]            dstrm_data,
  output logic                                        dstrm_dvalid,
  output logic [lpif_pkg::LPIF_CRC_W-1:0]             dstrm_crc,
  output logic                                        dstrm_crc_valid,
  output logic                                        dstrm_valid,

  // Upstream flit
  input  logic [lpif_pkg::LPIF_STATE_W-1:0]           ustrm_state,
  input  logic [lpif_pkg::LPIF_PROTID_W-1:0]          ustrm_protid,
  input  logic [lpif_pkg::LPIF_DATA_W-1:0]            ustrm_data,
  input  logic                                        ustrm_dvalid,
  input  logic [lpif_pkg::LPIF_CRC_W-1:0]             ustrm_crc,
  input  logic                                        ustrm_crc_valid,
  input  logic                                        ustrm_valid,

  // Debug status
  output logic [31:0]                                 rx_downstream_debug_status,
  output logic [31:0]                                 tx_upstream_debug_status
);

  logic [lpif_pkg::LPIF_WORD_W-1:0] tx_word;
  logic [lpif_pkg::LPIF_WORD_W-1:0] rx_word;

  lpif_sync_if sync_if ();

  ////////////////////
  // Auto sync
  lpif_auto_sync lpif_auto_sync_inst (
    .clk_wr        (clk_wr),
    .rst_n         (rst_n),
    .tx_online     (tx_online),
    .rx_online     (rx_online),
    .delay_x_value (delay_x_value),
    .delay_y_value (delay_y_value),
    .sync          (sync_if.src)
  );

  ////////////////////
  // Flit packing
  lpif_name lpif_name_inst (
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .tx_word         (tx_word),
    .rx_word         (rx_word),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid)
  );

  ////////////////////
  // PHY lanes, single clock for both directions
  lpif_concat #(
    .NUM_LANES (NUM_LANES)
  ) lpif_concat_inst (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .sync            (sync_if.snk),
    .tx_word         (tx_word),
    .rx_word         (rx_word),
    .tx_phy          (tx_phy),
    .rx_phy          (rx_phy),
    .rx_debug_status (rx_downstream_debug_status),
    .tx_debug_status (tx_upstream_debug_status)
  );

endmodule
